/* design/burst_pkg.sv */
`default_nettype none

package burst_pkg;

	localparam int num_slots = 4;
	localparam int slot_w = 2;
	localparam int burst_len = 16;
	localparam int beat_w = 4;
	localparam int data_w = 16;
	localparam int index_w = 5;

	// clk cycles from command edge to first data beat
	localparam int rd_latency = 8;
	localparam int wr_latency = 6;

	localparam int ca_w = 14;
	localparam logic bl_bar = 1'b1; // burst length 16
	localparam logic ap_bar = 1'b1; // no auto-precharge

	typedef enum logic [2:0] {
		slot_empty,
		slot_filling,
		slot_full,
		slot_waiting,   // command sent, data not started
		slot_returning
	} slot_state_e;

	typedef enum logic {
		req_read,
		req_write
	} req_type_e;

	typedef enum logic [2:0] {
		cmd_none,
		cmd_activate,
		cmd_read,
		cmd_write,
		cmd_precharge
	} ddr5_cmd_e;

endpackage

`default_nettype wire

/* design/burst_fill_ctrl.sv */
`default_nettype none

module burst_fill_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic arbiter_valid,
	input  burst_pkg::slot_state_e [burst_pkg::num_slots-1:0] slot_state,
	input  logic slot_match,
	input  logic freed,
	output logic fill_en,
	output logic fill_new,
	output logic [burst_pkg::slot_w-1:0] fill_slot,
	output logic [burst_pkg::slot_w-1:0] close_slot,
	output logic close_en,
	output logic start_new_burst
);
	import burst_pkg::*;

	logic [slot_w-1:0] cur_slot; // slot being filled, or the last one filled
	logic [slot_w:0] empty_cnt;
	logic [slot_w-1:0] lowest_empty;

	always_comb begin
		lowest_empty = '0;
		for (int s = num_slots - 1; s >= 0; s--) begin
			if (slot_state[s] == slot_empty) begin
				lowest_empty = slot_w'(s);
			end
		end
	end

	// open a new burst unless the request extends the one filling
	assign fill_en = arbiter_valid;
	assign fill_new = arbiter_valid && (slot_state[cur_slot] != slot_filling ||
		empty_cnt == num_slots || !slot_match);
	assign fill_slot = fill_new ? lowest_empty : cur_slot;

	assign close_slot = cur_slot;
	assign close_en = slot_state[cur_slot] == slot_filling && (fill_new || !arbiter_valid);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_slot <= '0;
			empty_cnt <= (slot_w+1)'(num_slots);
			start_new_burst <= 1'b1;
		end else begin
			if (fill_new) begin
				cur_slot <= lowest_empty;
			end
			empty_cnt <= empty_cnt + (slot_w+1)'(freed) - (slot_w+1)'(fill_new);
			start_new_burst <= empty_cnt > 1 || (empty_cnt == 1 && !arbiter_valid);
		end
	end

endmodule

`default_nettype wire

/* design/burst_slot_table.sv */
`default_nettype none

module burst_slot_table (
	input  logic clk,
	input  logic rst_n,
	input  logic fill_en,
	input  logic fill_new,
	input  logic [burst_pkg::slot_w-1:0] fill_slot,
	input  logic close_en,
	input  logic [burst_pkg::slot_w-1:0] close_slot,
	input  logic [1:0] arbiter_bg,
	input  logic [1:0] arbiter_bank,
	input  logic [15:0] arbiter_row,
	input  logic [9:0] arbiter_col,
	input  logic arbiter_is_write,
	input  logic [burst_pkg::data_w-1:0] arbiter_data,
	input  logic [burst_pkg::index_w-1:0] arbiter_index,
	input  logic set_waiting,
	input  logic [burst_pkg::slot_w-1:0] waiting_slot,
	input  logic set_returning,
	input  logic [burst_pkg::slot_w-1:0] returning_slot,
	input  logic capture_en,
	input  logic [burst_pkg::beat_w-1:0] capture_beat,
	input  logic [burst_pkg::slot_w-1:0] capture_slot,
	input  logic [burst_pkg::data_w-1:0] dq_in,
	input  logic clear_en,
	input  logic [burst_pkg::slot_w-1:0] clear_slot,
	input  logic [burst_pkg::beat_w-1:0] clear_bit,
	input  logic free_en,
	input  logic [burst_pkg::slot_w-1:0] free_slot,
	output logic slot_match,
	output burst_pkg::slot_state_e [burst_pkg::num_slots-1:0] slot_state,
	output burst_pkg::req_type_e [burst_pkg::num_slots-1:0] slot_type,
	output logic [burst_pkg::num_slots-1:0][1:0] slot_bank,
	output logic [burst_pkg::num_slots-1:0][1:0] slot_bg,
	output logic [burst_pkg::num_slots-1:0][15:0] slot_row,
	output logic [burst_pkg::num_slots-1:0][5:0] slot_col,
	output logic [burst_pkg::num_slots-1:0][burst_pkg::burst_len-1:0] slot_mask,
	output logic [burst_pkg::num_slots-1:0][burst_pkg::burst_len-1:0]
		[burst_pkg::data_w-1:0] slot_data,
	output logic [burst_pkg::num_slots-1:0][burst_pkg::burst_len-1:0]
		[burst_pkg::index_w-1:0] slot_index
);
	import burst_pkg::*;

	req_type_e arbiter_type;
	logic [beat_w-1:0] fill_beat; // low column bits pick the beat

	assign arbiter_type = arbiter_is_write ? req_write : req_read;
	assign fill_beat = arbiter_col[beat_w-1:0];

	// compare against the slot that is filling
	assign slot_match = slot_bg[close_slot] == arbiter_bg &&
		slot_bank[close_slot] == arbiter_bank &&
		slot_row[close_slot] == arbiter_row &&
		slot_col[close_slot] == arbiter_col[9:beat_w] &&
		slot_type[close_slot] == arbiter_type;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < num_slots; s++) begin
				slot_state[s] <= slot_empty;
				slot_mask[s] <= '0;
			end
		end else begin
			for (int s = 0; s < num_slots; s++) begin
				if (close_en && close_slot == s) slot_state[s] <= slot_full;
				if (fill_new && fill_slot == s) slot_state[s] <= slot_filling;
				if (set_waiting && waiting_slot == s) slot_state[s] <= slot_waiting;
				if (set_returning && returning_slot == s) slot_state[s] <= slot_returning;
				if (free_en && free_slot == s) slot_state[s] <= slot_empty;

				if (fill_en && fill_slot == s) begin
					if (fill_new) begin
						slot_mask[s] <= burst_len'(1) << fill_beat; // fresh burst
					end else begin
						slot_mask[s][fill_beat] <= 1'b1;
					end
				end
				if (clear_en && clear_slot == s) slot_mask[s][clear_bit] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			slot_data[fill_slot][fill_beat] <= arbiter_data; // read data lands on capture
			slot_index[fill_slot][fill_beat] <= arbiter_index;
		end
		if (fill_new) begin
			slot_type[fill_slot] <= arbiter_type;
			slot_bg[fill_slot] <= arbiter_bg;
			slot_bank[fill_slot] <= arbiter_bank;
			slot_row[fill_slot] <= arbiter_row;
			slot_col[fill_slot] <= arbiter_col[9:beat_w];
		end
		if (capture_en) begin
			slot_data[capture_slot][capture_beat] <= dq_in;
		end
	end

endmodule

`default_nettype wire

/* design/ddr5_cmd_encoder.sv */
`default_nettype none

module ddr5_cmd_encoder (
	input  logic clk,
	input  logic rst_n,
	input  burst_pkg::ddr5_cmd_e burst_cmd,
	input  logic [burst_pkg::slot_w-1:0] cmd_slot,
	input  logic [burst_pkg::num_slots-1:0][1:0] slot_bg,
	input  logic [burst_pkg::num_slots-1:0][1:0] slot_bank,
	input  logic [burst_pkg::num_slots-1:0][15:0] slot_row,
	input  logic [burst_pkg::num_slots-1:0][5:0] slot_col,
	input  logic [burst_pkg::num_slots-1:0][burst_pkg::burst_len-1:0] slot_mask,
	output logic cs_n,
	output logic [burst_pkg::ca_w-1:0] ca,
	output logic xfer_start,
	output logic [burst_pkg::slot_w-1:0] xfer_slot,
	output logic xfer_is_write
);
	import burst_pkg::*;

	ddr5_cmd_e pend_cmd; // command whose second phase is due
	logic [slot_w-1:0] pend_slot;
	logic phase2;
	logic [ca_w-1:0] p1_word;
	logic [ca_w-1:0] p2_word;

	always_comb begin
		p1_word = '0;
		case (burst_cmd)
			cmd_activate:  p1_word = {4'b0000, slot_bg[cmd_slot], slot_bank[cmd_slot],
				slot_row[cmd_slot][3:0], 2'b00};
			cmd_read:      p1_word = {4'b0000, slot_bg[cmd_slot], slot_bank[cmd_slot],
				bl_bar, 5'b11101};
			cmd_write:     p1_word = {4'b0000, slot_bg[cmd_slot], slot_bank[cmd_slot],
				bl_bar, 5'b01101};
			cmd_precharge: p1_word = {4'b0000, slot_bg[cmd_slot], slot_bank[cmd_slot],
				6'b011011};
			default:       p1_word = '0;
		endcase
	end

	always_comb begin
		p2_word = '0; // precharge has an empty second phase
		case (pend_cmd)
			cmd_activate: p2_word = {2'b00, slot_row[pend_slot][15:4]};
			cmd_read:     p2_word = {3'b000, ap_bar, 2'b00, slot_col[pend_slot], 2'b00};
			cmd_write:    p2_word = {2'b00, &slot_mask[pend_slot], 1'b1, 2'b00,
				slot_col[pend_slot], 2'b00}; // full mask sets wrp_bar
			default:      p2_word = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs_n <= 1'b1;
			ca <= '0;
			pend_cmd <= cmd_none;
			pend_slot <= '0;
			phase2 <= 1'b0;
		end else begin
			phase2 <= 1'b0;
			cs_n <= 1'b1;
			if (burst_cmd != cmd_none) begin
				cs_n <= 1'b0;
				ca <= p1_word;
				pend_cmd <= burst_cmd;
				pend_slot <= cmd_slot;
				phase2 <= 1'b1;
			end else if (phase2) begin
				ca <= p2_word;
			end else begin
				ca <= '0; // idle bus
			end
		end
	end

	assign xfer_start = burst_cmd == cmd_read || burst_cmd == cmd_write;
	assign xfer_slot = cmd_slot;
	assign xfer_is_write = burst_cmd == cmd_write;

endmodule

`default_nettype wire

/* design/ddr5_data_phase.sv */
`default_nettype none

module ddr5_data_phase (
	input  logic clk,
	input  logic rst_n,
	input  logic xfer_start,
	input  logic [burst_pkg::slot_w-1:0] xfer_slot,
	input  logic xfer_is_write,
	input  logic [burst_pkg::num_slots-1:0][burst_pkg::burst_len-1:0] slot_mask,
	input  logic [burst_pkg::num_slots-1:0][burst_pkg::burst_len-1:0]
		[burst_pkg::data_w-1:0] slot_data,
	output logic [burst_pkg::data_w-1:0] dq_out,
	output logic dq_oe,
	output logic [1:0] dm_n,
	output logic set_waiting,
	output logic [burst_pkg::slot_w-1:0] waiting_slot,
	output logic set_returning,
	output logic [burst_pkg::slot_w-1:0] returning_slot,
	output logic capture_en,
	output logic [burst_pkg::beat_w-1:0] capture_beat,
	output logic [burst_pkg::slot_w-1:0] capture_slot,
	output logic [burst_pkg::num_slots-1:0][burst_pkg::beat_w:0] beats_done
);
	import burst_pkg::*;

	logic [slot_w-1:0] act_slot;
	logic act_write;
	logic lat_wait; // counting down to the first beat
	logic beating;
	logic [beat_w-1:0] lat_cnt;
	logic [beat_w-1:0] beat;
	logic beat_mask;

	assign beat_mask = slot_mask[act_slot][beat];
	assign dq_out = slot_data[act_slot][beat];
	assign dq_oe = beating && act_write;
	assign dm_n = (dq_oe && beat_mask) ? 2'b00 : 2'b11; // both bytes together

	assign set_waiting = xfer_start;
	assign waiting_slot = xfer_slot;
	assign set_returning = beating && beat == '0;
	assign returning_slot = act_slot;

	assign capture_en = beating && !act_write && beat_mask;
	assign capture_beat = beat;
	assign capture_slot = act_slot;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			act_slot <= '0;
			act_write <= 1'b0;
			lat_wait <= 1'b0;
			beating <= 1'b0;
			lat_cnt <= '0;
			beat <= '0;
			beats_done <= '0;
		end else begin
			if (xfer_start) begin
				act_slot <= xfer_slot;
				act_write <= xfer_is_write;
				lat_cnt <= xfer_is_write ? beat_w'(wr_latency - 1) : beat_w'(rd_latency - 1);
				lat_wait <= 1'b1;
				beats_done[xfer_slot] <= '0;
			end else if (lat_wait) begin
				if (lat_cnt == '0) begin
					lat_wait <= 1'b0;
					beating <= 1'b1;
					beat <= '0;
				end else begin
					lat_cnt <= lat_cnt - 1'b1;
				end
			end
			if (beating) begin
				beat <= beat + 1'b1;
				beats_done[act_slot] <= (beat_w+1)'(beat) + 1'b1;
				if (beat == beat_w'(burst_len - 1)) beating <= 1'b0; // last beat
			end
		end
	end

endmodule

`default_nettype wire

/* design/burst_return.sv */
`default_nettype none

module burst_return (
	input  logic clk,
	input  logic rst_n,
	input  burst_pkg::slot_state_e [burst_pkg::num_slots-1:0] slot_state,
	input  logic [burst_pkg::num_slots-1:0][burst_pkg::burst_len-1:0] slot_mask,
	input  burst_pkg::req_type_e [burst_pkg::num_slots-1:0] slot_type,
	input  logic [burst_pkg::num_slots-1:0][burst_pkg::burst_len-1:0]
		[burst_pkg::data_w-1:0] slot_data,
	input  logic [burst_pkg::num_slots-1:0][burst_pkg::burst_len-1:0]
		[burst_pkg::index_w-1:0] slot_index,
	input  logic [burst_pkg::num_slots-1:0][burst_pkg::beat_w:0] beats_done,
	output logic clear_en,
	output logic [burst_pkg::slot_w-1:0] clear_slot,
	output logic [burst_pkg::beat_w-1:0] clear_bit,
	output logic free_en,
	output logic [burst_pkg::slot_w-1:0] free_slot,
	output logic returner_valid,
	output burst_pkg::req_type_e returner_type,
	output logic [burst_pkg::data_w-1:0] returner_data,
	output logic [burst_pkg::index_w-1:0] returner_index
);
	import burst_pkg::*;

	logic [slot_w-1:0] cur_slot; // sticks until its burst is drained
	logic [slot_w-1:0] sel_slot;
	logic sel_ok;
	logic any_bit;
	logic [beat_w-1:0] low_bit;

	always_comb begin
		sel_slot = cur_slot;
		if (slot_state[cur_slot] != slot_returning) begin
			for (int s = num_slots - 1; s >= 0; s--) begin
				if (slot_state[s] == slot_returning && slot_mask[s] != '0) sel_slot = slot_w'(s);
			end
		end
		sel_ok = slot_state[sel_slot] == slot_returning;
		any_bit = slot_mask[sel_slot] != '0;
		low_bit = '0;
		for (int b = burst_len - 1; b >= 0; b--) begin
			if (slot_mask[sel_slot][b]) low_bit = beat_w'(b);
		end
	end

	// a word goes back only once its beat has crossed the bus
	assign clear_en = sel_ok && any_bit && (beat_w+1)'(low_bit) < beats_done[sel_slot];
	assign clear_slot = sel_slot;
	assign clear_bit = low_bit;
	assign free_en = sel_ok && !any_bit;
	assign free_slot = sel_slot;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_slot <= '0;
			returner_valid <= 1'b0;
		end else begin
			cur_slot <= sel_slot;
			returner_valid <= clear_en;
		end
	end

	always_ff @(posedge clk) begin
		if (clear_en) begin
			returner_type <= slot_type[sel_slot];
			returner_data <= slot_data[sel_slot][low_bit];
			returner_index <= slot_index[sel_slot][low_bit];
		end
	end

endmodule

`default_nettype wire

/* design/burst_handler.sv */
`default_nettype none

module burst_handler (
	input  logic clk,
	input  logic rst_n,
	// timing controller
	output burst_pkg::slot_state_e [burst_pkg::num_slots-1:0] out_burst_state,
	output burst_pkg::req_type_e [burst_pkg::num_slots-1:0] out_burst_type,
	output logic [burst_pkg::num_slots-1:0][1:0] out_burst_bank,
	output logic [burst_pkg::num_slots-1:0][1:0] out_burst_bg,
	output logic [burst_pkg::num_slots-1:0][15:0] out_burst_row,
	input  burst_pkg::ddr5_cmd_e burst_cmd,
	input  logic [burst_pkg::slot_w-1:0] cmd_slot,
	// bank arbiter
	output logic start_new_burst,
	input  logic arbiter_valid,
	input  logic [1:0] arbiter_bg,
	input  logic [1:0] arbiter_bank,
	input  logic [15:0] arbiter_row,
	input  logic [9:0] arbiter_col,
	input  logic arbiter_is_write,
	input  logic [burst_pkg::data_w-1:0] arbiter_data,
	input  logic [burst_pkg::index_w-1:0] arbiter_index,
	// memory pins
	output logic cs_n,
	output logic [burst_pkg::ca_w-1:0] ca,
	output logic [1:0] dm_n,
	output logic [burst_pkg::data_w-1:0] dq_out,
	output logic dq_oe,
	input  logic [burst_pkg::data_w-1:0] dq_in,
	// returner
	output logic returner_valid,
	output burst_pkg::req_type_e returner_type,
	output logic [burst_pkg::data_w-1:0] returner_data,
	output logic [burst_pkg::index_w-1:0] returner_index
);
	import burst_pkg::*;

	logic fill_en;
	logic fill_new;
	logic [slot_w-1:0] fill_slot;
	logic close_en;
	logic [slot_w-1:0] close_slot;
	logic slot_match;
	logic [num_slots-1:0][5:0] slot_col;
	logic [num_slots-1:0][burst_len-1:0] slot_mask;
	logic [num_slots-1:0][burst_len-1:0][data_w-1:0] slot_data;
	logic [num_slots-1:0][burst_len-1:0][index_w-1:0] slot_index;
	logic set_waiting;
	logic [slot_w-1:0] waiting_slot;
	logic set_returning;
	logic [slot_w-1:0] returning_slot;
	logic capture_en;
	logic [beat_w-1:0] capture_beat;
	logic [slot_w-1:0] capture_slot;
	logic clear_en;
	logic [slot_w-1:0] clear_slot;
	logic [beat_w-1:0] clear_bit;
	logic free_en;
	logic [slot_w-1:0] free_slot;
	logic xfer_start;
	logic [slot_w-1:0] xfer_slot;
	logic xfer_is_write;
	logic [num_slots-1:0][beat_w:0] beats_done;

	burst_fill_ctrl u_fill (
		.clk, .rst_n, .arbiter_valid, .slot_state(out_burst_state), .slot_match,
		.freed(free_en), .fill_en, .fill_new, .fill_slot, .close_slot, .close_en,
		.start_new_burst
	);

	burst_slot_table u_table (
		.clk, .rst_n, .fill_en, .fill_new, .fill_slot, .close_en, .close_slot,
		.arbiter_bg, .arbiter_bank, .arbiter_row, .arbiter_col, .arbiter_is_write,
		.arbiter_data, .arbiter_index, .set_waiting, .waiting_slot, .set_returning,
		.returning_slot, .capture_en, .capture_beat, .capture_slot, .dq_in, .clear_en,
		.clear_slot, .clear_bit, .free_en, .free_slot, .slot_match,
		.slot_state(out_burst_state), .slot_type(out_burst_type), .slot_bank(out_burst_bank),
		.slot_bg(out_burst_bg), .slot_row(out_burst_row), .slot_col, .slot_mask, .slot_data,
		.slot_index
	);

	ddr5_cmd_encoder u_cmd (
		.clk, .rst_n, .burst_cmd, .cmd_slot, .slot_bg(out_burst_bg),
		.slot_bank(out_burst_bank), .slot_row(out_burst_row), .slot_col, .slot_mask,
		.cs_n, .ca, .xfer_start, .xfer_slot, .xfer_is_write
	);

	ddr5_data_phase u_data (
		.clk, .rst_n, .xfer_start, .xfer_slot, .xfer_is_write, .slot_mask, .slot_data,
		.dq_out, .dq_oe, .dm_n, .set_waiting, .waiting_slot, .set_returning,
		.returning_slot, .capture_en, .capture_beat, .capture_slot, .beats_done
	);

	burst_return u_return (
		.clk, .rst_n, .slot_state(out_burst_state), .slot_mask, .slot_type(out_burst_type),
		.slot_data, .slot_index, .beats_done, .clear_en, .clear_slot, .clear_bit, .free_en,
		.free_slot, .returner_valid, .returner_type, .returner_data, .returner_index
	);

endmodule

`default_nettype wire

/* tb/burst_handler_properties.sv */
`default_nettype none

module burst_handler_properties (
	input logic clk,
	input logic rst_n,
	input burst_pkg::ddr5_cmd_e burst_cmd,
	input logic cs_n,
	input logic [burst_pkg::ca_w-1:0] ca,
	input logic dq_oe,
	input logic returner_valid,
	input logic [burst_pkg::index_w-1:0] returner_index
);
	timeunit 1ns;
	timeprecision 1ps;
	import burst_pkg::*;

	int violations = 0; // failed assertions so far
	logic [5:0] write_left; // cycles left until the latest write's last beat

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			write_left <= '0;
		end else if (burst_cmd == cmd_write) begin
			write_left <= 6'(wr_latency + burst_len);
		end else if (write_left != '0) begin
			write_left <= write_left - 1'b1;
		end
	end

	cs_single: assert property (@(posedge clk) disable iff (!rst_n) !cs_n |=> cs_n)
		else begin
			violations++;
			$error("cs_n low on two consecutive cycles");
		end

	// data window of a write is its last burst_len cycles
	oe_in_write: assert property (@(posedge clk) disable iff (!rst_n)
		dq_oe |-> write_left != '0 && write_left <= burst_len)
		else begin
			violations++;
			$error("dq_oe high outside a write data phase");
		end

	ret_index: assert property (@(posedge clk) disable iff (!rst_n)
		returner_valid |=> !returner_valid || returner_index != $past(returner_index))
		else begin
			violations++;
			$error("returner_valid repeated for index %0d", returner_index);
		end

	ca_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		cs_n && ca == '0 |=> $stable(ca) || !cs_n)
		else begin
			violations++;
			$error("ca changed while cs_n stayed high");
		end

endmodule

bind burst_handler burst_handler_properties props (
	.clk, .rst_n, .burst_cmd, .cs_n, .ca, .dq_oe, .returner_valid, .returner_index
);

`default_nettype wire

/* tb/tb_burst_handler.sv */
`default_nettype none

module tb_burst_handler;
	timeunit 1ns;
	timeprecision 1ps;
	import burst_pkg::*;

	localparam int timeout_cycles = 200;
	// write bursts in slots 0 and 1, read burst in slot 2
	localparam logic [1:0] bg_a = 2'd1;
	localparam logic [1:0] bank_a = 2'd2;
	localparam logic [15:0] row_a = 16'h1234;
	localparam logic [15:0] row_b = 16'h2345;
	localparam logic [5:0] colhi_a = 6'h05;
	localparam logic [1:0] bg_c = 2'd3;
	localparam logic [1:0] bank_c = 2'd1;
	localparam logic [15:0] row_c = 16'h3456;
	localparam logic [5:0] colhi_c = 6'h2a;

	logic clk;
	logic rst_n;
	ddr5_cmd_e burst_cmd;
	logic [slot_w-1:0] cmd_slot;
	logic arbiter_valid;
	logic [1:0] arbiter_bg;
	logic [1:0] arbiter_bank;
	logic [15:0] arbiter_row;
	logic [9:0] arbiter_col;
	logic arbiter_is_write;
	logic [data_w-1:0] arbiter_data;
	logic [index_w-1:0] arbiter_index;
	logic [data_w-1:0] dq_in;
	slot_state_e [num_slots-1:0] out_burst_state;
	req_type_e [num_slots-1:0] out_burst_type;
	logic [num_slots-1:0][1:0] out_burst_bank;
	logic [num_slots-1:0][1:0] out_burst_bg;
	logic [num_slots-1:0][15:0] out_burst_row;
	logic start_new_burst;
	logic cs_n;
	logic [ca_w-1:0] ca;
	logic [1:0] dm_n;
	logic [data_w-1:0] dq_out;
	logic dq_oe;
	logic returner_valid;
	req_type_e returner_type;
	logic [data_w-1:0] returner_data;
	logic [index_w-1:0] returner_index;

	logic [burst_len-1:0] exp_mask [num_slots];
	logic [data_w-1:0] exp_data [num_slots][burst_len];
	logic [index_w-1:0] exp_index [num_slots][burst_len];
	logic [31:0] used_index; // keeps indices unique
	integer seed;
	int cycle;
	int cmd_cycle; // cycle count at the last command edge
	req_type_e got_type [$];
	logic [data_w-1:0] got_data [$];
	logic [index_w-1:0] got_index [$];

	burst_handler dut (.*);

	always #2 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	always @(negedge clk) begin
		if (rst_n && returner_valid) begin
			got_type.push_back(returner_type);
			got_data.push_back(returner_data);
			got_index.push_back(returner_index);
		end
	end

	always @(posedge clk) begin
		if (dut.props.violations != 0) abort_run("a bound protocol assertion failed");
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input logic ok, input string msg);
		assert (ok) else abort_run($sformatf("Fail at %0t ns: %s", $time, msg));
	endtask

	task automatic timed_out(input string what);
		abort_run($sformatf("Timeout: gave up waiting for %s after %0d cycles", what,
			timeout_cycles));
	endtask

	// memory model answer for one read beat
	function automatic logic [data_w-1:0] model_data(input int slot, input int beat);
		return data_w'(32'hc000 + slot * 256 + beat * 5);
	endfunction

	function automatic logic [ca_w-1:0] phase1_word(input ddr5_cmd_e cmd,
		input logic [1:0] bg, input logic [1:0] bank, input logic [15:0] row);
		logic [5:0] low;
		case (cmd)
			cmd_activate: low = {row[3:0], 2'b00};
			cmd_read: low = {bl_bar, 5'b11101};
			cmd_write: low = {bl_bar, 5'b01101};
			default: low = 6'b011011; // precharge
		endcase
		return {4'b0000, bg, bank, low};
	endfunction

	function automatic logic [ca_w-1:0] phase2_word(input ddr5_cmd_e cmd,
		input logic [15:0] row, input logic [5:0] col_hi, input logic full_mask);
		case (cmd)
			cmd_activate: return {2'b00, row[15:4]};
			cmd_read: return {3'b000, ap_bar, 2'b00, col_hi, 2'b00};
			cmd_write: return {2'b00, full_mask, 1'b1, 2'b00, col_hi, 2'b00};
			default: return '0;
		endcase
	endfunction

	// random distinct beats, one request per cycle
	task automatic fill_burst(input int slot, input logic [1:0] bg, input logic [1:0] bank,
		input logic [15:0] row, input logic [5:0] col_hi, input logic is_write,
		input int count);
		int n;
		logic [beat_w-1:0] beat;
		logic [index_w-1:0] idx;
		n = 0;
		while (n < count) begin
			beat = beat_w'($random(seed));
			if (!exp_mask[slot][beat]) begin
				idx = index_w'($random(seed));
				while (used_index[idx]) begin
					idx = idx + 1'b1;
				end
				used_index[idx] = 1'b1;
				exp_mask[slot][beat] = 1'b1;
				exp_index[slot][beat] = idx;
				exp_data[slot][beat] = is_write ? data_w'($random(seed)) : model_data(slot, beat);
				@(posedge clk);
				arbiter_valid <= 1'b1;
				arbiter_bg <= bg;
				arbiter_bank <= bank;
				arbiter_row <= row;
				arbiter_col <= {col_hi, beat};
				arbiter_is_write <= is_write;
				arbiter_data <= is_write ? exp_data[slot][beat] : data_w'($random(seed));
				arbiter_index <= idx;
				n++;
			end
		end
	endtask

	task automatic issue_command(input ddr5_cmd_e cmd, input logic [slot_w-1:0] slot,
		input logic [ca_w-1:0] word1, input logic [ca_w-1:0] word2);
		@(posedge clk);
		burst_cmd <= cmd;
		cmd_slot <= slot;
		@(posedge clk);
		burst_cmd <= cmd_none;
		@(negedge clk);
		cmd_cycle = cycle;
		check(!cs_n && ca == word1, $sformatf("%s phase 1: cs_n %b ca %h, expected %h",
			cmd.name(), cs_n, ca, word1));
		@(negedge clk);
		check(cs_n && ca == word2, $sformatf("%s phase 2: cs_n %b ca %h, expected %h",
			cmd.name(), cs_n, ca, word2));
		@(negedge clk);
		check(cs_n && ca == '0, $sformatf("%s: ca %h not idle", cmd.name(), ca));
	endtask

	task automatic check_write_beats(input int slot);
		int n;
		n = 0;
		while (!dq_oe) begin
			if (n == timeout_cycles) timed_out("the first write beat on dq_oe");
			@(negedge clk);
			n++;
		end
		check(cycle - cmd_cycle == wr_latency,
			$sformatf("first write beat %0d cycles after command", cycle - cmd_cycle));
		for (int b = 0; b < burst_len; b++) begin
			check(dq_oe, $sformatf("dq_oe low at write beat %0d", b));
			check(dm_n == (exp_mask[slot][b] ? 2'b00 : 2'b11),
				$sformatf("dm_n %b at write beat %0d", dm_n, b));
			if (exp_mask[slot][b]) begin
				check(dq_out == exp_data[slot][b], $sformatf("dq_out %h at beat %0d, expected %h",
					dq_out, b, exp_data[slot][b]));
			end
			@(negedge clk);
		end
		check(!dq_oe, "dq_oe still high after the last write beat");
	endtask

	// drive dq_in so that beat b is on the bus for its capture edge
	task automatic drive_read_data(input int slot);
		while (cycle - cmd_cycle < rd_latency - 1) begin
			@(negedge clk);
		end
		for (int b = 0; b < burst_len; b++) begin
			@(posedge clk);
			dq_in <= model_data(slot, b);
		end
		@(posedge clk);
		dq_in <= '0;
	endtask

	// returns must come back in column order
	task automatic check_returns(input int slot, input req_type_e kind);
		int n;
		int k;
		int count;
		count = $countones(exp_mask[slot]);
		n = 0;
		while (got_index.size() < count) begin
			if (n == timeout_cycles) timed_out($sformatf("%0d returned words of slot %0d",
				count, slot));
			@(posedge clk);
			n++;
		end
		k = 0;
		for (int b = 0; b < burst_len; b++) begin
			if (exp_mask[slot][b]) begin
				check(got_type[k] == kind && got_index[k] == exp_index[slot][b] &&
					got_data[k] == exp_data[slot][b], $sformatf(
					"return %0d of slot %0d: %s idx %0d data %h, expected idx %0d data %h", k,
					slot, got_type[k].name(), got_index[k], got_data[k], exp_index[slot][b],
					exp_data[slot][b]));
				k++;
			end
		end
		check(got_index.size() == count, $sformatf("%0d words returned, expected %0d",
			got_index.size(), count));
		got_type.delete();
		got_data.delete();
		got_index.delete();
	endtask

	task automatic wait_slot_empty(input int slot);
		int n;
		n = 0;
		while (out_burst_state[slot] != slot_empty) begin
			if (n == timeout_cycles) timed_out($sformatf("slot %0d to become empty", slot));
			@(negedge clk);
			n++;
		end
	endtask

	initial begin
		seed = 36;
		clk = 1'b0;
		rst_n = 1'b0;
		burst_cmd = cmd_none;
		cmd_slot = '0;
		arbiter_valid = 1'b0;
		arbiter_bg = '0;
		arbiter_bank = '0;
		arbiter_row = '0;
		arbiter_col = '0;
		arbiter_is_write = 1'b0;
		arbiter_data = '0;
		arbiter_index = '0;
		dq_in = '0;
		cycle = 0;
		cmd_cycle = 0;
		used_index = '0;
		for (int s = 0; s < num_slots; s++) begin
			exp_mask[s] = '0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check(cs_n && !returner_valid, "cs_n or returner_valid wrong after reset");
		check(start_new_burst, "start_new_burst low after reset");
		for (int s = 0; s < num_slots; s++) begin
			check(out_burst_state[s] == slot_empty, $sformatf("slot %0d not empty after reset", s));
		end

		fill_burst(0, bg_a, bank_a, row_a, colhi_a, 1'b1, 8);
		fill_burst(1, bg_a, bank_a, row_b, colhi_a, 1'b1, 1);
		fill_burst(2, bg_c, bank_c, row_c, colhi_c, 1'b0, 6);
		@(posedge clk);
		arbiter_valid <= 1'b0;
		@(negedge clk);
		check(!start_new_burst, "start_new_burst high with one slot empty and requests flowing");
		@(negedge clk);
		check(start_new_burst, "start_new_burst low after requests stopped");
		check(out_burst_state[0] == slot_full && out_burst_state[1] == slot_full &&
			out_burst_state[2] == slot_full && out_burst_state[3] == slot_empty,
			"slot states after filling");
		check(out_burst_row[0] == row_a && out_burst_row[1] == row_b,
			$sformatf("rows %h %h", out_burst_row[0], out_burst_row[1]));
		check(out_burst_bg[0] == bg_a && out_burst_bank[0] == bank_a &&
			out_burst_bg[2] == bg_c && out_burst_bank[2] == bank_c,
			$sformatf("bank group and bank %0d/%0d and %0d/%0d", out_burst_bg[0],
			out_burst_bank[0], out_burst_bg[2], out_burst_bank[2]));
		check(out_burst_type[0] == req_write && out_burst_type[2] == req_read, "slot types");

		issue_command(cmd_activate, 0, phase1_word(cmd_activate, bg_a, bank_a, row_a),
			phase2_word(cmd_activate, row_a, colhi_a, 1'b0));
		issue_command(cmd_write, 0, phase1_word(cmd_write, bg_a, bank_a, row_a),
			phase2_word(cmd_write, row_a, colhi_a, &exp_mask[0]));
		check_write_beats(0);
		check_returns(0, req_write);
		wait_slot_empty(0);
		issue_command(cmd_precharge, 0, phase1_word(cmd_precharge, bg_a, bank_a, row_a),
			phase2_word(cmd_precharge, row_a, colhi_a, 1'b0));

		issue_command(cmd_activate, 2, phase1_word(cmd_activate, bg_c, bank_c, row_c),
			phase2_word(cmd_activate, row_c, colhi_c, 1'b0));
		issue_command(cmd_read, 2, phase1_word(cmd_read, bg_c, bank_c, row_c),
			phase2_word(cmd_read, row_c, colhi_c, 1'b0));
		drive_read_data(2);
		check_returns(2, req_read);
		wait_slot_empty(2);

		repeat (4) @(posedge clk);
		if (dut.props.violations == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("SIMULATION FAILED");
			$fatal(1, "protocol assertions failed");
		end
	end

endmodule

`default_nettype wire

/* sources.f */
design/burst_pkg.sv
design/burst_fill_ctrl.sv
design/burst_slot_table.sv
design/ddr5_cmd_encoder.sv
design/ddr5_data_phase.sv
design/burst_return.sv
design/burst_handler.sv
tb/burst_handler_properties.sv
tb/tb_burst_handler.sv
